/* all.f */
drr_pkg.sv
queue_if.sv
queue_slot.sv
uop_queue.sv
reg_file.sv
addr_gen.sv
d_rrag_top.sv
d_rrag_sva.sv
tb_d_rrag.sv

/* Makefile */
# Verilator flow for the decode to rrag queue

VERILATOR ?= verilator
TOP       ?= tb_d_rrag
FLIST     ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIMFLAGS  ?= +verilator+error+limit+100

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, fail if the log reports failure"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) $(SIMFLAGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "sim failed" $(LOG); then echo "test FAILED"; exit 1; fi
	@if ! grep -q "sim passed" $(LOG); then echo "test FAILED, no result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb_d_rrag.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_d_rrag;
    import drr_pkg::*;

    typedef enum {k_idle, k_rfw, k_qwr, k_stall, k_clr, k_mod} kind_e;

    // one row is one clock cycle
    typedef struct {
        kind_e                         kind;
        logic [reg_idx_w-1:0]          idx;
        logic [reg_w-1:0]              data;
        logic [meta_w-1:0]             meta;
        logic                          is_imm;
        logic [opnd_w-1:0]             opnd;
        logic [queue_depth-1:0]        modv;
        logic [queue_depth*meta_w-1:0] newm;
    } row_t;

    logic                          clk;
    logic                          arst_n;
    logic                          wr;
    logic [meta_w-1:0]             meta_in;
    logic [payload_w-1:0]          payload_in;
    logic                          clr;
    logic [queue_depth-1:0]        modify_vector;
    logic [queue_depth*meta_w-1:0] new_meta_vector;
    logic                          rf_we;
    logic [reg_idx_w-1:0]          rf_waddr;
    logic [reg_w-1:0]              rf_wdata;
    logic                          stall;
    logic                          full;
    logic                          empty;
    logic [queue_depth*meta_w-1:0] old_meta_vector;
    logic                          res_valid;
    logic                          res_fault;
    logic [reg_w-1:0]              res_eip;
    logic [reg_w-1:0]              res_value;

    row_t        rows[$];
    logic [31:0] seed = 32'h1e41;
    logic [31:0] next_eip = 32'h0040_1000;

    // reference model of queue contents and registers
    logic [meta_w-1:0]    mq_meta[$];
    logic [payload_w-1:0] mq_pl[$];
    logic [reg_w-1:0]     m_regs[num_regs];
    logic                 stall_lvl;

    // result due at the next check
    logic             exp_pending;
    logic             exp_fault;
    logic [reg_w-1:0] exp_eip;
    logic [reg_w-1:0] exp_value;

    int n_mismatch = 0;
    int n_missing = 0;
    int n_extra = 0;
    int n_assert = 0;
    int cycles = 0;
    int limit = 0;

    d_rrag_top DUT (
        .clk             (clk),
        .arst_n          (arst_n),
        .wr              (wr),
        .meta_in         (meta_in),
        .payload_in      (payload_in),
        .clr             (clr),
        .modify_vector   (modify_vector),
        .new_meta_vector (new_meta_vector),
        .rf_we           (rf_we),
        .rf_waddr        (rf_waddr),
        .rf_wdata        (rf_wdata),
        .stall           (stall),
        .full            (full),
        .empty           (empty),
        .old_meta_vector (old_meta_vector),
        .res_valid       (res_valid),
        .res_fault       (res_fault),
        .res_eip         (res_eip),
        .res_value       (res_value)
    );

    always #2 clk = ~clk;

    // run length guard
    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("timeout: run did not end within %0d cycles", limit);
            $display("sim failed");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic row_t ctl_row(input kind_e k, input logic [reg_w-1:0] d);
        row_t r;
        r = '{k, '0, d, '0, 1'b0, '0, '0, '0};
        return r;
    endfunction

    // queue write with a fresh eip and a random operand
    task automatic entry_row(input logic [meta_w-1:0] m, input logic imm);
        row_t        r;
        opnd_u       o;
        logic [31:0] x;
        r = ctl_row(k_qwr, next_eip);
        next_eip += 32'd4;
        x = lcg_next();
        if (imm) begin
            o.imm.rsvd = '0;
            o.imm.imm  = lcg_next();
        end else begin
            o.mem.disp  = lcg_next();
            o.mem.base  = x[31:29];
            o.mem.index = x[28:26];
            o.mem.scale = x[25:24];
        end
        r.meta   = m;
        r.is_imm = imm;
        r.opnd   = o;
        rows.push_back(r);
    endtask

    task automatic reg_write_row(input int i, input logic [reg_w-1:0] d);
        row_t r;
        r = ctl_row(k_rfw, d);
        r.idx = reg_idx_w'(i);
        rows.push_back(r);
    endtask

    task automatic idle_rows(input int n);
        for (int i = 0; i < n; i++) begin
            rows.push_back(ctl_row(k_idle, '0));
        end
    endtask

    task automatic build_table();
        row_t r;
        for (int i = 0; i < num_regs; i++) begin
            reg_write_row(i, lcg_next());
        end
        // immediates
        for (int i = 0; i < 4; i++) begin
            entry_row(2'b10, 1'b1);
        end
        // memory refs, register update half way
        for (int i = 0; i < 6; i++) begin
            entry_row(2'b10, 1'b0);
            if (i == 2) begin
                reg_write_row(5, lcg_next());
            end
        end
        idle_rows(2);
        // fill past depth while stalled, two writes are lost
        rows.push_back(ctl_row(k_stall, 32'd1));
        for (int i = 0; i < queue_depth + 2; i++) begin
            entry_row(2'b10, i[0]);
        end
        rows.push_back(ctl_row(k_stall, 32'd0));
        idle_rows(10);
        // squash age 1, fault age 3, invalid fault age 5
        rows.push_back(ctl_row(k_stall, 32'd1));
        for (int i = 0; i < 6; i++) begin
            entry_row((i % 3 == 2) ? 2'b11 : 2'b10, 1'b0);
        end
        r = ctl_row(k_mod, '0);
        r.modv = 8'b0010_1010;
        r.newm = 16'h04c0;
        rows.push_back(r);
        rows.push_back(ctl_row(k_stall, 32'd0));
        idle_rows(8);
        // clear a partial queue, then refill
        rows.push_back(ctl_row(k_stall, 32'd1));
        for (int i = 0; i < 3; i++) begin
            entry_row(2'b10, 1'b1);
        end
        rows.push_back(ctl_row(k_clr, '0));
        rows.push_back(ctl_row(k_stall, 32'd0));
        for (int i = 0; i < 3; i++) begin
            entry_row(2'b10, 1'b0);
        end
        idle_rows(6);
    endtask

    // value by the rrag rule, from the model registers
    function automatic logic [reg_w-1:0] expect_value(input logic [payload_w-1:0] pl);
        opnd_u o;
        o = pl[pl_opnd_hi:pl_opnd_lo];
        if (pl[pl_is_imm]) begin
            return o.imm.imm;
        end
        return m_regs[o.mem.base] + (m_regs[o.mem.index] << o.mem.scale) + o.mem.disp;
    endfunction

    task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %0h exp %0h", name, got, exp);
            n_mismatch++;
        end
    endtask

    // outputs after the last rising edge
    task automatic check_outputs();
        logic [queue_depth*meta_w-1:0] omv;
        omv = '0;
        for (int a = 0; a < mq_meta.size(); a++) begin
            omv[a*meta_w +: meta_w] = mq_meta[a];
        end
        compare("full", 64'(full), 64'(mq_meta.size() == queue_depth));
        compare("empty", 64'(empty), 64'(mq_meta.size() == 0));
        compare("old_meta_vector", 64'(old_meta_vector), 64'(omv));
        if (res_valid === 1'b1 && !exp_pending) begin
            $display("unexpected result with eip %h, no valid entry was popped", res_eip);
            n_extra++;
        end else if (res_valid !== 1'b1 && exp_pending) begin
            $display("missing result for the entry with eip %h", exp_eip);
            n_missing++;
        end else if (exp_pending) begin
            compare("res_fault", 64'(res_fault), 64'(exp_fault));
            compare("res_eip", 64'(res_eip), 64'(exp_eip));
            compare("res_value", 64'(res_value), 64'(exp_value));
        end
    endtask

    // drive one row and step the model past the coming edge
    task automatic apply_row(input row_t r);
        logic full_now;
        logic pop_now;
        wr = 1'b0;
        clr = 1'b0;
        rf_we = 1'b0;
        modify_vector = '0;
        new_meta_vector = '0;
        if (r.kind == k_stall) begin
            stall_lvl = r.data[0];
        end
        stall = stall_lvl;
        full_now = (mq_meta.size() == queue_depth);
        pop_now = !stall_lvl && (mq_meta.size() > 0);
        // head result uses pre-edge meta and registers
        exp_pending = 1'b0;
        if (pop_now && mq_meta[0][meta_valid]) begin
            exp_pending = 1'b1;
            exp_fault = mq_meta[0][meta_fault];
            exp_eip = mq_pl[0][pl_eip_hi:pl_eip_lo];
            exp_value = expect_value(mq_pl[0]);
        end
        if (r.kind == k_mod) begin
            modify_vector = r.modv;
            new_meta_vector = r.newm;
            for (int a = 0; a < mq_meta.size(); a++) begin
                if (r.modv[a]) begin
                    mq_meta[a] = r.newm[a*meta_w +: meta_w];
                end
            end
        end
        if (pop_now) begin
            void'(mq_meta.pop_front());
            void'(mq_pl.pop_front());
        end
        if (r.kind == k_clr) begin
            clr = 1'b1;
            mq_meta.delete();
            mq_pl.delete();
        end
        if (r.kind == k_qwr) begin
            wr = 1'b1;
            meta_in = r.meta;
            payload_in = {r.data, r.is_imm, r.opnd};
            if (!full_now) begin
                mq_meta.push_back(r.meta);
                mq_pl.push_back(payload_in);
            end
        end
        if (r.kind == k_rfw) begin
            rf_we = 1'b1;
            rf_waddr = r.idx;
            rf_wdata = r.data;
            m_regs[r.idx] = r.data;
        end
    endtask

    task automatic run_cycle(input row_t r);
        @(negedge clk);
        check_outputs();
        apply_row(r);
    endtask

    initial begin
        clk = 1'b0;
        arst_n = 1'b0;
        wr = 1'b0;
        meta_in = '0;
        payload_in = '0;
        clr = 1'b0;
        modify_vector = '0;
        new_meta_vector = '0;
        rf_we = 1'b0;
        rf_waddr = '0;
        rf_wdata = '0;
        stall = 1'b0;
        stall_lvl = 1'b0;
        exp_pending = 1'b0;
        for (int i = 0; i < num_regs; i++) begin
            m_regs[i] = '0;
        end
        build_table();
        limit = 8 * rows.size() + 50;
        repeat (2) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        foreach (rows[i]) begin
            run_cycle(rows[i]);
        end
        // drain whatever the model still holds
        while (mq_meta.size() > 0 || exp_pending) begin
            run_cycle(ctl_row(k_idle, '0));
        end
        n_assert = DUT.rrag_chk.fail_count;
        $display("errors: mismatch=%0d missing=%0d unexpected=%0d assertion=%0d",
                 n_mismatch, n_missing, n_extra, n_assert);
        if (n_mismatch + n_missing + n_extra + n_assert == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* d_rrag_sva.sv */
`timescale 1ns/10ps
`default_nettype none

// queue head and result strobe protocol
module d_rrag_sva (
    input logic clk,
    input logic arst_n,
    input logic empty,
    input logic pop,
    input logic full,
    input logic res_valid
);

    // assertion failures so far
    int fail_count = 0;

    // head only leaves when there is one
    a_pop_empty: assert property (@(posedge clk) disable iff (!arst_n) !(pop && empty))
        else begin
            $error("pop raised while the queue is empty");
            fail_count++;
        end

    a_full_empty: assert property (@(posedge clk) disable iff (!arst_n) !(full && empty))
        else begin
            $error("full and empty high together");
            fail_count++;
        end

    // every strobe cycle needs its own pop one cycle before
    a_one_result: assert property (@(posedge clk) disable iff (!arst_n) res_valid |-> $past(pop))
        else begin
            $error("res_valid without a pop in the cycle before");
            fail_count++;
        end

    // first edge out of reset sees the idle queue
    a_reset_state: assert property (@(posedge clk) $rose(arst_n) |-> !full && empty)
        else begin
            $error("queue not empty right after reset");
            fail_count++;
        end

endmodule

// queue status, pop strobe and result strobe all meet at the top
bind d_rrag_top d_rrag_sva rrag_chk (
    .clk       (clk),
    .arst_n    (arst_n),
    .empty     (empty),
    .pop       (q_bus.pop),
    .full      (full),
    .res_valid (res_valid)
);

`default_nettype wire

/* d_rrag_top.sv */
`timescale 1ns/10ps
`default_nettype none

// decode to rrag latch queue with its rrag stage
module d_rrag_top (
    input  logic                                                clk,
    input  logic                                                arst_n,
    input  logic                                                wr,
    input  logic [drr_pkg::meta_w-1:0]                         meta_in,
    input  logic [drr_pkg::payload_w-1:0]                      payload_in,
    input  logic                                                clr,
    input  logic [drr_pkg::queue_depth-1:0]                    modify_vector,
    input  logic [drr_pkg::queue_depth*drr_pkg::meta_w-1:0]    new_meta_vector,
    input  logic                                                rf_we,
    input  logic [drr_pkg::reg_idx_w-1:0]                      rf_waddr,
    input  logic [drr_pkg::reg_w-1:0]                          rf_wdata,
    input  logic                                                stall,
    output logic                                                full,
    output logic                                                empty,
    output logic [drr_pkg::queue_depth*drr_pkg::meta_w-1:0]    old_meta_vector,
    output logic                                                res_valid,
    output logic                                                res_fault,
    output logic [drr_pkg::reg_w-1:0]                          res_eip,
    output logic [drr_pkg::reg_w-1:0]                          res_value
);
    import drr_pkg::*;

    // queue head to rrag stage
    queue_if q_bus ();

    // base and index read ports
    logic [reg_idx_w-1:0] rf_raddr_a;
    logic [reg_idx_w-1:0] rf_raddr_b;
    logic [reg_w-1:0]     rf_rdata_a;
    logic [reg_w-1:0]     rf_rdata_b;

    assign empty = q_bus.empty;

    uop_queue #(
        .depth (queue_depth)
    ) u_queue (
        .clk             (clk),
        .arst_n          (arst_n),
        .wr              (wr),
        .meta_in         (meta_in),
        .payload_in      (payload_in),
        .clr             (clr),
        .modify_vector   (modify_vector),
        .new_meta_vector (new_meta_vector),
        .full            (full),
        .old_meta_vector (old_meta_vector),
        .q               (q_bus.producer)
    );

    reg_file u_rf (
        .clk     (clk),
        .arst_n  (arst_n),
        .we      (rf_we),
        .waddr   (rf_waddr),
        .wdata   (rf_wdata),
        .raddr_a (rf_raddr_a),
        .raddr_b (rf_raddr_b),
        .rdata_a (rf_rdata_a),
        .rdata_b (rf_rdata_b)
    );

    addr_gen u_agen (
        .clk        (clk),
        .arst_n     (arst_n),
        .stall      (stall),
        .q          (q_bus.consumer),
        .rf_raddr_a (rf_raddr_a),
        .rf_raddr_b (rf_raddr_b),
        .rf_rdata_a (rf_rdata_a),
        .rf_rdata_b (rf_rdata_b),
        .res_valid  (res_valid),
        .res_fault  (res_fault),
        .res_eip    (res_eip),
        .res_value  (res_value)
    );

endmodule

`default_nettype wire

/* addr_gen.sv */
`timescale 1ns/10ps
`default_nettype none

// rrag stage
// pops the queue head and produces an immediate or effective address
module addr_gen (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           stall,
    queue_if.consumer                      q,
    output logic [drr_pkg::reg_idx_w-1:0] rf_raddr_a,
    output logic [drr_pkg::reg_idx_w-1:0] rf_raddr_b,
    input  logic [drr_pkg::reg_w-1:0]     rf_rdata_a,
    input  logic [drr_pkg::reg_w-1:0]     rf_rdata_b,
    output logic                           res_valid,
    output logic                           res_fault,
    output logic [drr_pkg::reg_w-1:0]     res_eip,
    output logic [drr_pkg::reg_w-1:0]     res_value
);
    import drr_pkg::*;

    opnd_u            opnd;
    logic             is_imm;
    logic [reg_w-1:0] eip;
    logic [reg_w-1:0] scaled_index;
    logic [reg_w-1:0] mem_addr;
    logic [reg_w-1:0] value;
    logic             accept;

    // take the head whenever one is there
    assign q.pop = ~q.empty & ~stall;

    // split the fixed part
    assign eip    = q.head_payload[pl_eip_hi:pl_eip_lo];
    assign is_imm = q.head_payload[pl_is_imm];
    assign opnd   = q.head_payload[pl_opnd_hi:pl_opnd_lo];

    // base and index reads, don't care for immediates
    assign rf_raddr_a = opnd.mem.base;
    assign rf_raddr_b = opnd.mem.index;

    // base + (index << scale) + disp, wraps at 32 bits
    assign scaled_index = rf_rdata_b << opnd.mem.scale;
    assign mem_addr     = rf_rdata_a + scaled_index + opnd.mem.disp;

    assign value = is_imm ? opnd.imm.imm : mem_addr;

    // squashed entries leave without a result
    assign accept = q.pop & q.head_meta[meta_valid];

    // result strobe
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= accept;
        end
    end

    // result fields, qualified by res_valid
    // fault rides along unchanged
    always_ff @(posedge clk) begin
        if (accept) begin
            res_fault <= q.head_meta[meta_fault];
            res_eip   <= eip;
            res_value <= value;
        end
    end

endmodule

`default_nettype wire

/* reg_file.sv */
`timescale 1ns/10ps
`default_nettype none

// architectural registers seen by address generation
module reg_file (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           we,
    input  logic [drr_pkg::reg_idx_w-1:0] waddr,
    input  logic [drr_pkg::reg_w-1:0]     wdata,
    input  logic [drr_pkg::reg_idx_w-1:0] raddr_a,
    input  logic [drr_pkg::reg_idx_w-1:0] raddr_b,
    output logic [drr_pkg::reg_w-1:0]     rdata_a,
    output logic [drr_pkg::reg_w-1:0]     rdata_b
);
    import drr_pkg::*;

    logic [reg_w-1:0] regs [num_regs];

    // single write port from outside the core slice
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // base read
    assign rdata_a = regs[raddr_a];
    // index read
    assign rdata_b = regs[raddr_b];

endmodule

`default_nettype wire

/* uop_queue.sv */
`timescale 1ns/10ps
`default_nettype none

// circular queue of decode latches
// depth of 2 or more
module uop_queue #(
    parameter int depth = drr_pkg::queue_depth
) (
    input  logic                                 clk,
    input  logic                                 arst_n,
    input  logic                                 wr,
    input  logic [drr_pkg::meta_w-1:0]          meta_in,
    input  logic [drr_pkg::payload_w-1:0]       payload_in,
    input  logic                                 clr,
    input  logic [depth-1:0]                     modify_vector,
    input  logic [depth*drr_pkg::meta_w-1:0]    new_meta_vector,
    output logic                                 full,
    output logic [depth*drr_pkg::meta_w-1:0]    old_meta_vector,
    queue_if.producer                            q
);
    import drr_pkg::*;

    localparam int ptr_w = $clog2(depth);
    localparam int cnt_w = $clog2(depth + 1);

    logic [ptr_w-1:0]     head;
    logic [ptr_w-1:0]     tail;
    logic [cnt_w-1:0]     count;
    logic                 push;
    logic                 pop;

    // per physical slot
    logic [meta_w-1:0]    slot_meta    [depth];
    logic [payload_w-1:0] slot_payload [depth];
    logic [meta_w-1:0]    slot_new     [depth];
    logic                 slot_mod     [depth];
    logic                 slot_load    [depth];

    // wrap at depth, not at a power of two
    function automatic logic [ptr_w-1:0] inc_ptr(input logic [ptr_w-1:0] p);
        if (p == ptr_w'(depth - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    // status from occupancy
    assign q.empty = (count == '0);
    assign full    = (count == cnt_w'(depth));

    // writes while full are dropped
    assign push = wr & ~full;
    assign pop  = q.pop & ~q.empty;

    // head entry straight out of its slot
    assign q.head_meta    = slot_meta[head];
    assign q.head_payload = slot_payload[head];

    // pointers and count, clr wins
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (clr) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push) begin
                tail <= inc_ptr(tail);
            end
            if (pop) begin
                head <= inc_ptr(head);
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    // age to slot mapping for readback and modify
    always_comb begin
        int phys;
        for (int s = 0; s < depth; s++) begin
            slot_mod[s]  = clr;
            slot_new[s]  = '0;
            slot_load[s] = push & ~clr & (tail == ptr_w'(s));
        end
        old_meta_vector = '0;
        for (int a = 0; a < depth; a++) begin
            phys = int'(head) + a;
            if (phys >= depth) begin
                phys = phys - depth;
            end
            // ages past the count hold nothing
            if (a < int'(count)) begin
                old_meta_vector[a*meta_w +: meta_w] = slot_meta[phys];
                if (!clr && modify_vector[a]) begin
                    slot_mod[phys] = 1'b1;
                    slot_new[phys] = new_meta_vector[a*meta_w +: meta_w];
                end
            end
        end
    end

    // the latch entries
    // clr rewrites every meta to zero
    for (genvar s = 0; s < depth; s++) begin : g_slot
        queue_slot u_slot (
            .clk       (clk),
            .arst_n    (arst_n),
            .load      (slot_load[s]),
            .meta_d    (meta_in),
            .payload_d (payload_in),
            .modify    (slot_mod[s]),
            .new_meta  (slot_new[s]),
            .meta_q    (slot_meta[s]),
            .payload_q (slot_payload[s])
        );
    end

endmodule

`default_nettype wire

/* queue_slot.sv */
`timescale 1ns/10ps
`default_nettype none

// one latch entry of the decode queue
module queue_slot (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           load,
    input  logic [drr_pkg::meta_w-1:0]    meta_d,
    input  logic [drr_pkg::payload_w-1:0] payload_d,
    input  logic                           modify,
    input  logic [drr_pkg::meta_w-1:0]    new_meta,
    output logic [drr_pkg::meta_w-1:0]    meta_q,
    output logic [drr_pkg::payload_w-1:0] payload_q
);

    // modifiable part
    // load has priority, modify only touches meta
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            meta_q <= '0;
        end else if (load) begin
            meta_q <= meta_d;
        end else if (modify) begin
            meta_q <= new_meta;
        end
    end

    // fixed part, written once per entry
    always_ff @(posedge clk) begin
        if (load) begin
            payload_q <= payload_d;
        end
    end

endmodule

`default_nettype wire

/* queue_if.sv */
`timescale 1ns/10ps
`default_nettype none

// head of the decode queue as seen by the rrag stage
interface queue_if;
    import drr_pkg::*;

    // no entry held
    logic                 empty;
    // oldest entry, valid while empty is low
    logic [meta_w-1:0]    head_meta;
    logic [payload_w-1:0] head_payload;
    // head leaves the queue at this edge
    logic                 pop;

    modport producer (
        output empty,
        output head_meta,
        output head_payload,
        input  pop
    );

    modport consumer (
        input  empty,
        input  head_meta,
        input  head_payload,
        output pop
    );

endinterface

`default_nettype wire

/* drr_pkg.sv */
`default_nettype none

package drr_pkg;

    // modifiable part of a queued micro-op
    localparam int meta_w     = 2;
    localparam int meta_valid = 1;
    localparam int meta_fault = 0;

    // architectural register file
    localparam int reg_w     = 32;
    localparam int reg_idx_w = 3;
    localparam int num_regs  = 8;

    // operand word and its fields
    localparam int opnd_w  = 40;
    localparam int scale_w = 2;

    // fixed part, eip on top, then is_imm, then operand
    localparam int payload_w  = 73;
    localparam int pl_eip_hi  = 72;
    localparam int pl_eip_lo  = 41;
    localparam int pl_is_imm  = 40;
    localparam int pl_opnd_hi = 39;
    localparam int pl_opnd_lo = 0;

    // default latch queue depth
    localparam int queue_depth = 8;

    // immediate view, upper bits unused
    typedef struct packed {
        logic [opnd_w-reg_w-1:0] rsvd;
        logic [reg_w-1:0]        imm;
    } opnd_imm_t;

    // memory reference view
    typedef struct packed {
        logic [reg_w-1:0]     disp;
        logic [reg_idx_w-1:0] base;
        logic [reg_idx_w-1:0] index;
        logic [scale_w-1:0]   scale;
    } opnd_mem_t;

    // one operand word, decoded by is_imm
    typedef union packed {
        opnd_imm_t imm;
        opnd_mem_t mem;
    } opnd_u;

endpackage

`default_nettype wire
